/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := adc_acq_tb
RTL_TOP   := adc_acq_top
FILELIST  := adc_acq.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* adc_acq.f */
+incdir+hw
hw/acq_ctrl_pkg.sv
hw/acq_frame_pkg.sv
hw/trig_addr_fifo.sv
hw/circ_buffer.sv
hw/acq_sequencer.sv
hw/acq_frame_mux.sv
hw/adc_acq_top.sv
testbench/adc_acq_tb.sv

/* hw/acq_config.svh */
`ifndef ACQ_CONFIG_SVH
`define ACQ_CONFIG_SVH

// circular buffer address width, 256 words of two packed 12-bit samples
`define ACQ_CBUF_AW 8

// words kept ahead of the trigger point
`define ACQ_PRETRIG 6

// bursts of four words per waveform, one count per fill type
`define ACQ_BURSTS_T1 2
`define ACQ_BURSTS_T2 4
`define ACQ_BURSTS_T3 8

// trigger address fifo holds 4 entries
`define ACQ_TFIFO_AW 2

// flops in each enable/trigger synchronizer
`define ACQ_SYNC_STAGES 4

`endif

/* hw/acq_ctrl_pkg.sv */
package acq_ctrl_pkg;

    // fill type is {enable1, enable0}
    // off means not armed
    typedef enum logic [1:0] {
        off = 2'd0,
        t1  = 2'd1,
        t2  = 2'd2,
        t3  = 2'd3
    } fill_type_t;

    // bit positions in the one-hot state vector
    typedef enum logic [4:0] {
        idle,
        watch_for_trig,
        fill_init1,
        fill_init2,
        waveform_init1,
        waveform_init2,
        waveform_init3,
        run1,
        run2,
        run3,
        run4,
        waveform_tst1,
        waveform_tst2,
        checksum1,
        checksum2,
        ddr3_wait,
        done
    } seq_state_t;

endpackage

/* hw/acq_frame_mux.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module acq_frame_mux (
    input  logic                      clk,
    input  logic                      adc_acq_full_reset,
    input  acq_ctrl_pkg::fill_type_t  fill_type,
    input  logic [`ACQ_CBUF_AW-1:0]   trig_addr,
    input  logic [7:0]                burst_count,
    input  logic [127:0]              burst_data,
    input  logic                      fill_hdr_sel,
    input  logic                      wfm_hdr_sel,
    input  logic                      dat_sel,
    input  logic                      checksum_sel,
    input  logic                      checksum_update,
    input  logic                      out_valid,
    input  logic                      fill_cntr_en,
    output logic [127:0]              frame_word,
    output acq_frame_pkg::frame_kind_t frame_kind,
    output logic                      frame_valid
);
    logic [31:0]               fill_cnt;
    logic [`ACQ_CBUF_AW-1:0]   trig_hold;
    acq_frame_pkg::checksum_t  csum;
    acq_frame_pkg::checksum_t  burst_sum;

    assign burst_sum = burst_data[31:0] + burst_data[63:32] +
                       burst_data[95:64] + burst_data[127:96];

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            fill_cnt    <= '0;
            csum        <= '0;
            frame_valid <= 1'b0;
        end else begin
            // word was built on the select strobe, goes out one cycle later
            frame_valid <= out_valid;
            if (fill_cntr_en)
                fill_cnt <= fill_cnt + 32'd1;
            // sum restarts with every fill header
            if (fill_hdr_sel)
                csum <= '0;
            else if (checksum_update)
                csum <= csum + burst_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_hdr_sel) begin
            // fifo head gets popped before the waveform header, keep a copy
            trig_hold  <= trig_addr;
            frame_word <= {64'd0, 30'd0, fill_type, fill_cnt};
            frame_kind <= acq_frame_pkg::fill_hdr;
        end else if (wfm_hdr_sel) begin
            frame_word <= {64'd0, 24'd0, burst_count,
                           {(32-`ACQ_CBUF_AW){1'b0}}, trig_hold};
            frame_kind <= acq_frame_pkg::wfm_hdr;
        end else if (dat_sel) begin
            frame_word <= burst_data;
            frame_kind <= acq_frame_pkg::data;
        end else if (checksum_sel) begin
            frame_word <= {96'd0, csum};
            frame_kind <= acq_frame_pkg::checksum;
        end
    end

endmodule

/* hw/acq_frame_pkg.sv */
package acq_frame_pkg;

    // tag sent alongside each 128-bit frame word
    typedef enum logic [1:0] {
        fill_hdr = 2'd0,
        wfm_hdr  = 2'd1,
        data     = 2'd2,
        checksum = 2'd3
    } frame_kind_t;

    // running sum over all data lanes of a waveform, wraps at 2^32
    typedef logic [31:0] checksum_t;

endpackage

/* hw/acq_sequencer.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module acq_sequencer (
    input  logic                     clk,
    input  logic                     adc_acq_full_reset,
    input  logic                     acq_enable0,
    input  logic                     acq_enable1,
    input  logic                     acq_trig,
    input  logic                     ddr3_wr_done,
    input  logic                     trig_fifo_empty,
    output acq_ctrl_pkg::fill_type_t fill_type,
    output logic                     trig_pulse,
    output logic                     trig_addr_rd_en,
    output logic                     init_circ_buf_rd_addr,
    output logic                     inc_circ_buf_rd_addr,
    output logic                     latch_circ_buf_dat,
    output logic                     fill_hdr_sel,
    output logic                     wfm_hdr_sel,
    output logic                     dat_sel,
    output logic                     checksum_sel,
    output logic                     checksum_update,
    output logic                     out_valid,
    output logic                     fill_cntr_en,
    output logic [7:0]               burst_count,
    output logic                     acq_enabled,
    output logic                     acq_done,
    output logic                     sm_idle
);
    localparam int sync_len = `ACQ_SYNC_STAGES;

    // synchronizer chains with the msb as the last stage
    logic [sync_len-1:0]         en0_sync;
    logic [sync_len-1:0]         en1_sync;
    logic [sync_len-1:0]         trig_sync;
    logic                        trig_sync_d;
    logic [1:0]                  wr_done_sync;
    logic                        mode_enabled;
    logic [7:0]                  burst_cntr;
    logic                        run_next;
    logic [acq_ctrl_pkg::done:0] cs;
    logic [acq_ctrl_pkg::done:0] ns;

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            en0_sync     <= '0;
            en1_sync     <= '0;
            trig_sync    <= '0;
            trig_sync_d  <= 1'b0;
            wr_done_sync <= '0;
            mode_enabled <= 1'b0;
            fill_type    <= acq_ctrl_pkg::off;
            trig_pulse   <= 1'b0;
        end else begin
            en0_sync     <= {en0_sync[sync_len-2:0], acq_enable0};
            en1_sync     <= {en1_sync[sync_len-2:0], acq_enable1};
            trig_sync    <= {trig_sync[sync_len-2:0], acq_trig};
            trig_sync_d  <= trig_sync[sync_len-1];
            wr_done_sync <= {wr_done_sync[0], ddr3_wr_done};
            // armed whenever either enable is set
            mode_enabled <= en0_sync[sync_len-1] | en1_sync[sync_len-1];
            fill_type    <= acq_ctrl_pkg::fill_type_t'({en1_sync[sync_len-1],
                                                        en0_sync[sync_len-1]});
            // rising edge at the last stage passes only while armed
            trig_pulse   <= trig_sync[sync_len-1] & ~trig_sync_d & mode_enabled;
        end
    end

    // bursts per waveform for the current fill type
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_count <= '0;
        end else begin
            case (fill_type)
                acq_ctrl_pkg::t1: burst_count <= 8'(`ACQ_BURSTS_T1);
                acq_ctrl_pkg::t2: burst_count <= 8'(`ACQ_BURSTS_T2);
                acq_ctrl_pkg::t3: burst_count <= 8'(`ACQ_BURSTS_T3);
                default:          burst_count <= '0;
            endcase
        end
    end

    // loaded once per waveform and counted down once per burst
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            burst_cntr <= '0;
        end else if (cs[acq_ctrl_pkg::waveform_init2]) begin
            burst_cntr <= burst_count;
        end else if (cs[acq_ctrl_pkg::run1]) begin
            burst_cntr <= burst_cntr - 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            cs                    <= '0;
            cs[acq_ctrl_pkg::idle] <= 1'b1;
        end else begin
            cs <= ns;
        end
    end

    always_comb begin
        ns = '0;
        case (1'b1)
            cs[acq_ctrl_pkg::idle]: begin
                if (mode_enabled)
                    ns[acq_ctrl_pkg::watch_for_trig] = 1'b1;
                else
                    ns[acq_ctrl_pkg::idle] = 1'b1;
            end
            // wait for a captured start address or drop out if disarmed
            cs[acq_ctrl_pkg::watch_for_trig]: begin
                if (!trig_fifo_empty)
                    ns[acq_ctrl_pkg::fill_init1] = 1'b1;
                else if (!mode_enabled)
                    ns[acq_ctrl_pkg::idle] = 1'b1;
                else
                    ns[acq_ctrl_pkg::watch_for_trig] = 1'b1;
            end
            cs[acq_ctrl_pkg::fill_init1]:     ns[acq_ctrl_pkg::fill_init2] = 1'b1;
            cs[acq_ctrl_pkg::fill_init2]:     ns[acq_ctrl_pkg::waveform_init1] = 1'b1;
            cs[acq_ctrl_pkg::waveform_init1]: ns[acq_ctrl_pkg::waveform_init2] = 1'b1;
            cs[acq_ctrl_pkg::waveform_init2]: ns[acq_ctrl_pkg::waveform_init3] = 1'b1;
            cs[acq_ctrl_pkg::waveform_init3]: ns[acq_ctrl_pkg::run1] = 1'b1;
            cs[acq_ctrl_pkg::run1]:           ns[acq_ctrl_pkg::run2] = 1'b1;
            cs[acq_ctrl_pkg::run2]:           ns[acq_ctrl_pkg::run3] = 1'b1;
            cs[acq_ctrl_pkg::run3]:           ns[acq_ctrl_pkg::run4] = 1'b1;
            // counter already hit zero in run1 of the last burst
            cs[acq_ctrl_pkg::run4]: begin
                if (burst_cntr == 8'd0)
                    ns[acq_ctrl_pkg::waveform_tst1] = 1'b1;
                else
                    ns[acq_ctrl_pkg::run1] = 1'b1;
            end
            cs[acq_ctrl_pkg::waveform_tst1]:  ns[acq_ctrl_pkg::waveform_tst2] = 1'b1;
            cs[acq_ctrl_pkg::waveform_tst2]:  ns[acq_ctrl_pkg::checksum1] = 1'b1;
            cs[acq_ctrl_pkg::checksum1]:      ns[acq_ctrl_pkg::checksum2] = 1'b1;
            cs[acq_ctrl_pkg::checksum2]:      ns[acq_ctrl_pkg::ddr3_wait] = 1'b1;
            cs[acq_ctrl_pkg::ddr3_wait]: begin
                if (wr_done_sync[1])
                    ns[acq_ctrl_pkg::done] = 1'b1;
                else
                    ns[acq_ctrl_pkg::ddr3_wait] = 1'b1;
            end
            // hold until the trigger level drops so it cannot retrigger
            cs[acq_ctrl_pkg::done]: begin
                if (mode_enabled && trig_sync[sync_len-1])
                    ns[acq_ctrl_pkg::done] = 1'b1;
                else
                    ns[acq_ctrl_pkg::idle] = 1'b1;
            end
            default: ns[acq_ctrl_pkg::idle] = 1'b1;
        endcase
    end

    assign run_next = ns[acq_ctrl_pkg::run1] | ns[acq_ctrl_pkg::run2] |
                      ns[acq_ctrl_pkg::run3] | ns[acq_ctrl_pkg::run4];

    // strobes are high for the cycle spent in the state they belong to
    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            sm_idle               <= 1'b0;
            acq_enabled           <= 1'b0;
            fill_hdr_sel          <= 1'b0;
            trig_addr_rd_en       <= 1'b0;
            init_circ_buf_rd_addr <= 1'b0;
            wfm_hdr_sel           <= 1'b0;
            inc_circ_buf_rd_addr  <= 1'b0;
            latch_circ_buf_dat    <= 1'b0;
            dat_sel               <= 1'b0;
            checksum_update       <= 1'b0;
            out_valid             <= 1'b0;
            checksum_sel          <= 1'b0;
            fill_cntr_en          <= 1'b0;
            acq_done              <= 1'b0;
        end else begin
            sm_idle               <= ns[acq_ctrl_pkg::idle];
            acq_enabled           <= ~(ns[acq_ctrl_pkg::idle] |
                                       ns[acq_ctrl_pkg::watch_for_trig]);
            fill_hdr_sel          <= ns[acq_ctrl_pkg::fill_init1];
            // pop and read address load share the cycle while head is still valid
            trig_addr_rd_en       <= ns[acq_ctrl_pkg::waveform_init1];
            init_circ_buf_rd_addr <= ns[acq_ctrl_pkg::waveform_init1];
            wfm_hdr_sel           <= ns[acq_ctrl_pkg::waveform_init2];
            inc_circ_buf_rd_addr  <= ns[acq_ctrl_pkg::waveform_init3] | run_next;
            latch_circ_buf_dat    <= run_next;
            // full burst sits in the latch the cycle after run4
            dat_sel               <= cs[acq_ctrl_pkg::run4];
            checksum_update       <= cs[acq_ctrl_pkg::run4];
            out_valid             <= ns[acq_ctrl_pkg::fill_init2] |
                                     ns[acq_ctrl_pkg::waveform_init3] |
                                     dat_sel |
                                     ns[acq_ctrl_pkg::checksum2];
            checksum_sel          <= ns[acq_ctrl_pkg::checksum1];
            fill_cntr_en          <= ns[acq_ctrl_pkg::checksum2];
            // single pulse on entry to done
            acq_done              <= ns[acq_ctrl_pkg::done] & ~cs[acq_ctrl_pkg::done];
        end
    end

endmodule

/* hw/adc_acq_top.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module adc_acq_top (
    input  logic                       clk,
    input  logic                       adc_acq_full_reset,
    input  logic [31:0]                adc_word,
    input  logic                       adc_word_valid,
    input  logic                       acq_enable0,
    input  logic                       acq_enable1,
    input  logic                       acq_trig,
    input  logic                       ddr3_wr_done,
    output logic [127:0]               frame_word,
    output acq_frame_pkg::frame_kind_t frame_kind,
    output logic                       frame_valid,
    output logic                       acq_enabled,
    output logic                       acq_done,
    output logic                       sm_idle
);
    acq_ctrl_pkg::fill_type_t  fill_type;
    logic                      trig_pulse;
    logic                      trig_addr_rd_en;
    logic                      init_rd;
    logic                      inc_rd;
    logic                      latch;
    logic                      fill_hdr_sel;
    logic                      wfm_hdr_sel;
    logic                      dat_sel;
    logic                      checksum_sel;
    logic                      checksum_update;
    logic                      out_valid;
    logic                      fill_cntr_en;
    logic [7:0]                burst_count;
    logic                      fifo_empty;
    logic                      capture_push;
    logic [`ACQ_CBUF_AW-1:0]   capture_addr;
    logic [`ACQ_CBUF_AW-1:0]   trig_addr;
    logic [127:0]              burst_data;

    acq_sequencer u_seq (
        .clk                   (clk),
        .adc_acq_full_reset    (adc_acq_full_reset),
        .acq_enable0           (acq_enable0),
        .acq_enable1           (acq_enable1),
        .acq_trig              (acq_trig),
        .ddr3_wr_done          (ddr3_wr_done),
        .trig_fifo_empty       (fifo_empty),
        .fill_type             (fill_type),
        .trig_pulse            (trig_pulse),
        .trig_addr_rd_en       (trig_addr_rd_en),
        .init_circ_buf_rd_addr (init_rd),
        .inc_circ_buf_rd_addr  (inc_rd),
        .latch_circ_buf_dat    (latch),
        .fill_hdr_sel          (fill_hdr_sel),
        .wfm_hdr_sel           (wfm_hdr_sel),
        .dat_sel               (dat_sel),
        .checksum_sel          (checksum_sel),
        .checksum_update       (checksum_update),
        .out_valid             (out_valid),
        .fill_cntr_en          (fill_cntr_en),
        .burst_count           (burst_count),
        .acq_enabled           (acq_enabled),
        .acq_done              (acq_done),
        .sm_idle               (sm_idle)
    );

    trig_addr_fifo u_tfifo (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .push               (capture_push),
        .wr_addr            (capture_addr),
        .pop                (trig_addr_rd_en),
        .head               (trig_addr),
        .empty              (fifo_empty)
    );

    circ_buffer u_cbuf (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_word           (adc_word),
        .adc_word_valid     (adc_word_valid),
        .trig_pulse         (trig_pulse),
        .trig_addr          (trig_addr),
        .init_rd            (init_rd),
        .inc_rd             (inc_rd),
        .latch              (latch),
        .capture_push       (capture_push),
        .capture_addr       (capture_addr),
        .burst_data         (burst_data)
    );

    acq_frame_mux u_mux (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .fill_type          (fill_type),
        .trig_addr          (trig_addr),
        .burst_count        (burst_count),
        .burst_data         (burst_data),
        .fill_hdr_sel       (fill_hdr_sel),
        .wfm_hdr_sel        (wfm_hdr_sel),
        .dat_sel            (dat_sel),
        .checksum_sel       (checksum_sel),
        .checksum_update    (checksum_update),
        .out_valid          (out_valid),
        .fill_cntr_en       (fill_cntr_en),
        .frame_word         (frame_word),
        .frame_kind         (frame_kind),
        .frame_valid        (frame_valid)
    );

endmodule

/* hw/circ_buffer.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module circ_buffer (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic [31:0]             adc_word,
    input  logic                    adc_word_valid,
    input  logic                    trig_pulse,
    input  logic [`ACQ_CBUF_AW-1:0] trig_addr,
    input  logic                    init_rd,
    input  logic                    inc_rd,
    input  logic                    latch,
    output logic                    capture_push,
    output logic [`ACQ_CBUF_AW-1:0] capture_addr,
    output logic [127:0]            burst_data
);
    localparam int aw    = `ACQ_CBUF_AW;
    localparam int depth = 1 << aw;

    logic [31:0]   mem [depth];
    logic [aw-1:0] wr_ptr;
    logic [aw-1:0] rd_addr;
    logic [31:0]   rd_data;

    // every strobed word goes in, oldest data is overwritten
    always_ff @(posedge clk) begin
        if (adc_word_valid)
            mem[wr_ptr] <= adc_word;
        // registered read, word ready one cycle after its address
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr       <= '0;
            rd_addr      <= '0;
            capture_push <= 1'b0;
        end else begin
            if (adc_word_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (init_rd)
                rd_addr <= trig_addr;
            else if (inc_rd)
                rd_addr <= rd_addr + 1'b1;
            capture_push <= trig_pulse;
        end
    end

    // start of the saved window, wraps below address zero
    always_ff @(posedge clk) begin
        if (trig_pulse)
            capture_addr <= wr_ptr - aw'(`ACQ_PRETRIG);
    end

    // new word enters the top lane so the oldest ends up in lane0
    always_ff @(posedge clk) begin
        if (latch)
            burst_data <= {rd_data, burst_data[127:32]};
    end

endmodule

/* hw/trig_addr_fifo.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module trig_addr_fifo (
    input  logic                    clk,
    input  logic                    adc_acq_full_reset,
    input  logic                    push,
    input  logic [`ACQ_CBUF_AW-1:0] wr_addr,
    input  logic                    pop,
    output logic [`ACQ_CBUF_AW-1:0] head,
    output logic                    empty
);
    localparam int aw    = `ACQ_TFIFO_AW;
    localparam int depth = 1 << aw;

    logic [`ACQ_CBUF_AW-1:0] mem [depth];
    // pointers carry one extra wrap bit
    logic [aw:0]             wr_ptr;
    logic [aw:0]             rd_ptr;
    logic                    full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
    // fall-through, oldest entry always on the output
    assign head  = mem[rd_ptr[aw-1:0]];

    always_ff @(posedge clk) begin
        if (push && !full)
            mem[wr_ptr[aw-1:0]] <= wr_addr;
    end

    always_ff @(posedge clk) begin
        if (adc_acq_full_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            // a trigger arriving while full is lost
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

/* testbench/adc_acq_tb.sv */
`timescale 1ns/1ps

`include "acq_config.svh"

module adc_acq_tb;

    localparam int clk_period    = 20;
    localparam int settle_cycles = 12;
    localparam int max_gap       = 16;
    localparam int max_ddr_delay = 16;
    // worst fill covers gap, trigger sync, headers, largest burst count, checksum and re-arm
    localparam int fill_cycles   = settle_cycles + max_gap + 40 + 4 * `ACQ_BURSTS_T3 +
                                   max_ddr_delay + 20;
    localparam int run_cycles    = 3 * fill_cycles + 100;
    // offset of the first saved word from the word written when the trigger is first seen high
    localparam int start_offset  = `ACQ_SYNC_STAGES + 1 - `ACQ_PRETRIG;

    logic                       clk;
    logic                       adc_acq_full_reset;
    logic [31:0]                adc_word;
    logic                       adc_word_valid;
    logic                       acq_enable0;
    logic                       acq_enable1;
    logic                       acq_trig;
    logic                       ddr3_wr_done;
    logic [127:0]               frame_word;
    acq_frame_pkg::frame_kind_t frame_kind;
    logic                       frame_valid;
    logic                       acq_enabled;
    logic                       acq_done;
    logic                       sm_idle;

    acq_ctrl_pkg::fill_type_t fill_plan [3];
    int                       seed;
    // windows set by the stimulus on the falling edge
    logic                     disarmed_window;
    logic                     fill_active;
    logic                     wr_done_raised;

    // reference model state owned by the monitor
    logic        trig_prev   = 1'b0;
    logic [31:0] trig_word   = '0;
    int          phase       = 0;
    int          data_left   = 0;
    int          frames_done = 0;
    logic [31:0] exp_lane    = '0;
    logic [31:0] lane_sum    = '0;

    adc_acq_top UUT (
        .clk                (clk),
        .adc_acq_full_reset (adc_acq_full_reset),
        .adc_word           (adc_word),
        .adc_word_valid     (adc_word_valid),
        .acq_enable0        (acq_enable0),
        .acq_enable1        (acq_enable1),
        .acq_trig           (acq_trig),
        .ddr3_wr_done       (ddr3_wr_done),
        .frame_word         (frame_word),
        .frame_kind         (frame_kind),
        .frame_valid        (frame_valid),
        .acq_enabled        (acq_enabled),
        .acq_done           (acq_done),
        .sm_idle            (sm_idle)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        stop_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp);
        assert (got == exp)
        else report_mismatch(name, 32'(got), 32'(exp));
    endtask

    function automatic logic [31:0] lane(input logic [127:0] w, input int idx);
        return w[32*idx +: 32];
    endfunction

    // burst counts per fill type as configured
    function automatic int bursts_for(input acq_ctrl_pkg::fill_type_t t);
        case (t)
            acq_ctrl_pkg::t1: return `ACQ_BURSTS_T1;
            acq_ctrl_pkg::t2: return `ACQ_BURSTS_T2;
            acq_ctrl_pkg::t3: return `ACQ_BURSTS_T3;
            default:          return 0;
        endcase
    endfunction

    task automatic expect_lane(input int idx, input logic [31:0] exp);
        assert (lane(frame_word, idx) == exp)
        else report_mismatch($sformatf("frame_word lane%0d", idx), lane(frame_word, idx), exp);
    endtask

    // one frame word against the expected order and content
    task automatic check_frame();
        acq_frame_pkg::frame_kind_t exp_kind;
        logic [31:0]                start_word;
        int                         i;
        if (phase == 0)
            exp_kind = acq_frame_pkg::fill_hdr;
        else if (phase == 1)
            exp_kind = acq_frame_pkg::wfm_hdr;
        else if (data_left > 0)
            exp_kind = acq_frame_pkg::data;
        else
            exp_kind = acq_frame_pkg::checksum;
        assert (frame_kind == exp_kind)
        else report_mismatch("frame_kind", 32'(frame_kind), 32'(exp_kind));
        case (exp_kind)
            acq_frame_pkg::fill_hdr: begin
                assert (frames_done < 3)
                else stop_run("a fill header arrived after the last planned fill");
                // fill number is the count of fills already sent
                expect_lane(0, 32'(frames_done));
                expect_lane(1, 32'(fill_plan[frames_done]));
                expect_lane(2, 32'd0);
                expect_lane(3, 32'd0);
                lane_sum = '0;
                phase = 1;
            end
            acq_frame_pkg::wfm_hdr: begin
                start_word = trig_word + 32'(start_offset);
                // buffer address of the first saved word
                expect_lane(0, 32'(start_word[`ACQ_CBUF_AW-1:0]));
                expect_lane(1, 32'(bursts_for(fill_plan[frames_done])));
                expect_lane(2, 32'd0);
                expect_lane(3, 32'd0);
                exp_lane = start_word;
                data_left = bursts_for(fill_plan[frames_done]);
                phase = 2;
            end
            acq_frame_pkg::data: begin
                // adc words count up so lanes run on across bursts
                for (i = 0; i < 4; i++) begin
                    expect_lane(i, exp_lane);
                    lane_sum = lane_sum + exp_lane;
                    exp_lane = exp_lane + 32'd1;
                end
                data_left--;
            end
            default: begin
                expect_lane(0, lane_sum);
                expect_lane(1, 32'd0);
                expect_lane(2, 32'd0);
                expect_lane(3, 32'd0);
                frames_done++;
                phase = 0;
            end
        endcase
    endtask

    // sampled on the rising edge with inputs settled since the falling edge
    always @(posedge clk) begin
        if (!adc_acq_full_reset) begin
            if (acq_trig && !trig_prev)
                trig_word = adc_word;
            trig_prev = acq_trig;
            if (frame_valid)
                check_frame();
        end
    end

    a_quiet_when_disarmed: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        disarmed_window |-> (!frame_valid && !acq_enabled && sm_idle))
        else stop_run("a trigger with both enables low started a fill");

    a_done_after_wr_done: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        acq_done |-> wr_done_raised)
        else stop_run("acq_done pulsed before ddr3_wr_done was raised");

    a_done_one_cycle: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        acq_done |=> !acq_done)
        else stop_run("acq_done stayed high for more than one cycle");

    a_frame_in_fill: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        frame_valid |-> acq_enabled)
        else stop_run("frame_valid was high while acq_enabled was low");

    a_done_in_fill: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        acq_done |-> acq_enabled)
        else stop_run("acq_done was high while acq_enabled was low");

    a_enabled_only_in_fill: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        acq_enabled |-> fill_active)
        else stop_run("acq_enabled was high outside a triggered fill");

    a_enabled_until_idle: assert property (@(posedge clk) disable iff (adc_acq_full_reset)
        $fell(acq_enabled) |-> sm_idle)
        else stop_run("acq_enabled dropped before the return to idle");

    // adc source puts word n at buffer address n mod 256
    initial begin
        adc_word = '0;
        adc_word_valid = 1'b0;
        @(negedge adc_acq_full_reset);
        adc_word_valid = 1'b1;
        forever begin
            @(negedge clk);
            adc_word = adc_word + 32'd1;
        end
    end

    initial begin
        #(run_cycles * clk_period);
        stop_run($sformatf("timeout, the run did not end within %0d clock cycles", run_cycles));
    end

    initial begin
        int f;
        int gap;
        int delay;
        seed = 32'h9fba_5904;
        adc_acq_full_reset = 1'b1;
        acq_enable0 = 1'b0;
        acq_enable1 = 1'b0;
        acq_trig = 1'b0;
        ddr3_wr_done = 1'b0;
        disarmed_window = 1'b0;
        fill_active = 1'b0;
        wr_done_raised = 1'b0;
        fill_plan[0] = acq_ctrl_pkg::t2;
        fill_plan[1] = acq_ctrl_pkg::t1;
        fill_plan[2] = acq_ctrl_pkg::t3;

        repeat (2) @(posedge clk);
        @(negedge clk);
        expect_bit("frame_valid", frame_valid, 1'b0);
        expect_bit("acq_enabled", acq_enabled, 1'b0);
        expect_bit("acq_done", acq_done, 1'b0);
        expect_bit("sm_idle", sm_idle, 1'b0);
        adc_acq_full_reset = 1'b0;
        @(negedge clk);
        // idle is reported one cycle after release
        expect_bit("sm_idle", sm_idle, 1'b1);
        expect_bit("frame_valid", frame_valid, 1'b0);
        expect_bit("acq_enabled", acq_enabled, 1'b0);
        expect_bit("acq_done", acq_done, 1'b0);

        // trigger while disarmed must be dropped
        disarmed_window = 1'b1;
        acq_trig = 1'b1;
        repeat (10) @(negedge clk);
        acq_trig = 1'b0;
        repeat (20) @(negedge clk);
        disarmed_window = 1'b0;

        for (f = 0; f < 3; f++) begin
            {acq_enable1, acq_enable0} = fill_plan[f];
            gap = settle_cycles + int'($unsigned($random(seed)) % max_gap);
            repeat (gap) @(negedge clk);
            fill_active = 1'b1;
            acq_trig = 1'b1;
            while (frames_done < f + 1)
                @(negedge clk);
            // memory writer takes a random time to finish
            delay = 1 + int'($unsigned($random(seed)) % max_ddr_delay);
            repeat (delay) @(negedge clk);
            wr_done_raised = 1'b1;
            ddr3_wr_done = 1'b1;
            while (!acq_done)
                @(negedge clk);
            ddr3_wr_done = 1'b0;
            acq_trig = 1'b0;
            // done state holds until the trigger level drops
            while (!sm_idle)
                @(negedge clk);
            fill_active = 1'b0;
            wr_done_raised = 1'b0;
        end

        repeat (10) @(negedge clk);
        if (frames_done == 3 && phase == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            stop_run($sformatf("only %0d of 3 fills completed", frames_done));
        end
    end

endmodule
